// File: tb.f
+incdir+logic
logic/isa_pkg.sv
logic/issue_pkg.sv
logic/issue_hazard_check.sv
logic/gpr_regfile.sv
logic/issue_register.sv
logic/issue_read_operands.sv
tests/tb_issue_read_operands.sv

// File: Bender.yml
package:
  name: issue_read_operands

dependencies: {}

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/issue_pkg.sv
      - logic/issue_hazard_check.sv
      - logic/gpr_regfile.sv
      - logic/issue_register.sv
      - logic/issue_read_operands.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_issue_read_operands.sv

// File: tests/tb_issue_read_operands.sv
// ----------------------------------------
// testbench for the issue and operand read stage
// clock, reset, directed and random stimulus,
// reference model, compare process, watchdog
// ----------------------------------------

`timescale 1ns/1ps

`include "issue_defs.svh"

module tb_issue_read_operands;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int NR_PORTS     = `ISSUE_NR_COMMIT_PORTS;
    localparam int RESET_CYCLES = 10;
    // six tests need fewer than 45 cycles in total
    localparam int TEST_CYCLES  = 60;
    localparam int MAX_CYCLES   = RESET_CYCLES + TEST_CYCLES + 50;

    // expected state of the stage after one clock edge
    typedef struct packed {
        logic      ack;
        fu_data_t  data;
        fu_valid_t valid;
        xlen_t     pc;
        logic      is_c;
    } expect_t;

    logic                            clk_i = 1'b0;
    logic                            rst_ni;
    logic                            flush;
    scoreboard_entry_t               instr;
    logic                            instr_valid;
    logic                            ack;
    reg_addr_t                       rs1_addr;
    reg_addr_t                       rs2_addr;
    xlen_t                           rs1_data;
    xlen_t                           rs2_data;
    logic                            rs1_valid;
    logic                            rs2_valid;
    clobber_table_t                  clobber;
    commit_port_t [NR_PORTS-1:0]     commit;
    fu_ready_t                       ready;
    fu_data_t                        fu_data;
    fu_valid_t                       valid;
    xlen_t                           pc;
    logic                            is_c;

    // architectural state as seen through the commit ports
    xlen_t   shadow [2**`ISSUE_REG_ADDR_SIZE];
    expect_t exp_q;
    int      errors    = 0;
    int      checks    = 0;
    int      cycles    = 0;
    int      test_base = 0;

    always #10 clk_i = ~clk_i;

    issue_read_operands #(
        .NR_COMMIT_PORTS ( NR_PORTS )
    ) issue_read_operands_inst (
        .clk_i               ( clk_i       ),
        .rst_ni              ( rst_ni      ),
        .flush_i             ( flush       ),
        .issue_instr_i       ( instr       ),
        .issue_instr_valid_i ( instr_valid ),
        .issue_ack_o         ( ack         ),
        .rs1_o               ( rs1_addr    ),
        .rs1_i               ( rs1_data    ),
        .rs1_valid_i         ( rs1_valid   ),
        .rs2_o               ( rs2_addr    ),
        .rs2_i               ( rs2_data    ),
        .rs2_valid_i         ( rs2_valid   ),
        .clobber_i           ( clobber     ),
        .commit_i            ( commit      ),
        .ready_i             ( ready       ),
        .fu_data_o           ( fu_data     ),
        .valid_o             ( valid       ),
        .pc_o                ( pc          ),
        .is_compressed_o     ( is_c        )
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic expect_t predict(scoreboard_entry_t ins, logic vld, logic pend);
        expect_t e;
        fu_t     own_a;
        fu_t     own_b;
        logic    hold;
        logic    busy;
        logic    rd_ok;
        e     = '0;
        hold  = 1'b0;
        own_a = clobber[ins.rs1];
        own_b = clobber[ins.rs2];
        // the shadow never writes x0 so it reads zero
        e.data.operand_a = shadow[ins.rs1];
        e.data.operand_b = shadow[ins.rs2];
        if (own_a != NONE) begin
            if (rs1_valid && own_a != CSR) begin
                e.data.operand_a = rs1_data;
            end else begin
                hold = 1'b1;
            end
        end
        if (own_b != NONE) begin
            if (rs2_valid && own_b != CSR) begin
                e.data.operand_b = rs2_data;
            end else begin
                hold = 1'b1;
            end
        end
        if (ins.use_pc) begin
            e.data.operand_a = ins.pc;
        end
        if (ins.use_imm && !(ins.fu inside {STORE, CTRL_FLOW})) begin
            e.data.operand_b = ins.result;
        end
        // load/store unit or the fixed latency unit
        busy  = (ins.fu inside {LOAD, STORE}) ? !ready.lsu : (ins.fu != NONE) && !ready.flu;
        rd_ok = (clobber[ins.rd] == NONE);
        for (int i = 0; i < NR_PORTS; i++) begin
            if (commit[i].we && commit[i].waddr == ins.rd) begin
                rd_ok = 1'b1;
            end
        end
        e.ack = vld && (ins.ex_valid || ins.fu == NONE || (!hold && !busy && rd_ok))
                && !(pend && ins.fu != MULT);
        e.data.fu       = ins.fu;
        e.data.op       = ins.op;
        e.data.imm      = ins.result;
        e.data.trans_id = ins.trans_id;
        e.pc            = ins.pc;
        e.is_c          = ins.is_compressed;
        if (e.ack && !ins.ex_valid && !flush) begin
            case (ins.fu)
                ALU:         e.valid.alu    = 1'b1;
                CTRL_FLOW:   e.valid.branch = 1'b1;
                LOAD, STORE: e.valid.lsu    = 1'b1;
                MULT:        e.valid.mult   = 1'b1;
                CSR:         e.valid.csr    = 1'b1;
                default:     e.valid        = '0;
            endcase
        end
        return e;
    endfunction

    // ----------------------------------------
    // compare process
    // ----------------------------------------
    // registered outputs still hold last cycle's values in the active region
    always @(posedge clk_i) begin : compare
        expect_t cur;
        if (rst_ni) begin
            cur    = predict(instr, instr_valid, exp_q.valid.mult);
            checks = checks + 5;
            assert (ack == cur.ack) else begin
                $display("Fail at %0t: ack %b, expected %b", $time, ack, cur.ack);
                errors++;
            end
            assert (rs1_addr == instr.rs1 && rs2_addr == instr.rs2) else begin
                $display("Fail at %0t: source index %0d/%0d, expected %0d/%0d", $time,
                         rs1_addr, rs2_addr, instr.rs1, instr.rs2);
                errors++;
            end
            assert (fu_data == exp_q.data) else begin
                $display("Fail at %0t: fu_data %h, expected %h", $time, fu_data, exp_q.data);
                errors++;
            end
            assert (valid == exp_q.valid) else begin
                $display("Fail at %0t: valid %b, expected %b", $time, valid, exp_q.valid);
                errors++;
            end
            assert (pc == exp_q.pc && is_c == exp_q.is_c) else begin
                $display("Fail at %0t: pc %h/%b, expected %h/%b", $time, pc, is_c,
                         exp_q.pc, exp_q.is_c);
                errors++;
            end
            // a later commit port wins on an address clash
            for (int i = 0; i < NR_PORTS; i++) begin
                if (commit[i].we && commit[i].waddr != '0) begin
                    shadow[commit[i].waddr] = commit[i].wdata;
                end
            end
            exp_q = cur;
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus helpers start and end at a falling edge
    // ----------------------------------------
    function automatic scoreboard_entry_t make_instr(fu_t fu, reg_addr_t rs1, reg_addr_t rs2,
                                                     reg_addr_t rd);
        scoreboard_entry_t s;
        s               = '0;
        s.pc            = $urandom & 32'hffff_fffc;
        s.trans_id      = trans_id_t'($urandom_range(7));
        s.fu            = fu;
        s.op            = fu_op_t'($urandom_range(13));
        s.rs1           = rs1;
        s.rs2           = rs2;
        s.rd            = rd;
        s.result        = $urandom;
        s.is_compressed = ($urandom_range(1) == 1);
        return s;
    endfunction

    task automatic check_value(string what, xlen_t got, xlen_t want);
        checks++;
        assert (got == want) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    // hold the instruction until the stage takes it
    task automatic issue_and_wait(scoreboard_entry_t ins);
        instr       = ins;
        instr_valid = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!ack);
        @(negedge clk_i);
        instr_valid = 1'b0;
    endtask

    task automatic accept_now(scoreboard_entry_t ins);
        instr       = ins;
        instr_valid = 1'b1;
        @(posedge clk_i);
        checks++;
        assert (ack) else begin
            $display("Fail at %0t: instruction not taken in its first cycle", $time);
            errors++;
        end
        @(negedge clk_i);
        instr_valid = 1'b0;
    endtask

    task automatic refuse(scoreboard_entry_t ins, int n);
        instr       = ins;
        instr_valid = 1'b1;
        repeat (n) begin
            @(posedge clk_i);
            checks++;
            assert (!ack) else begin
                $display("Fail at %0t: instruction taken while it should wait", $time);
                errors++;
            end
        end
        @(negedge clk_i);
        instr_valid = 1'b0;
    endtask

    task automatic write_regs(reg_addr_t a0, xlen_t d0, reg_addr_t a1, xlen_t d1);
        commit[0] = '{waddr: a0, wdata: d0, we: 1'b1};
        commit[1] = '{waddr: a1, wdata: d1, we: 1'b1};
        @(posedge clk_i);
        @(negedge clk_i);
        commit = '0;
    endtask

    task automatic clear_clobber();
        for (int r = 0; r < 2**`ISSUE_REG_ADDR_SIZE; r++) begin
            clobber[r] = NONE;
        end
    endtask

    task automatic end_test(string name);
        $display("test %-10s %s, %0d errors", name,
                 (errors == test_base) ? "ok" : "with errors", errors - test_base);
        test_base = errors;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin : main
        scoreboard_entry_t ins;
        xlen_t             w0;
        xlen_t             w1;
        fu_t               units [6];
        void'($urandom(32'hdba04486));
        units       = '{ALU, CTRL_FLOW, LOAD, STORE, MULT, CSR};
        rst_ni      = 1'b0;
        flush       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        rs1_data    = '0;
        rs2_data    = '0;
        rs1_valid   = 1'b0;
        rs2_valid   = 1'b0;
        commit      = '0;
        ready       = '1;
        exp_q       = '0;
        clear_clobber();
        foreach (shadow[r]) begin
            shadow[r] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;

        // register file readback
        w0 = $urandom;
        w1 = $urandom;
        write_regs(5, w0, 6, w1);
        issue_and_wait(make_instr(ALU, 5, 6, 7));
        check_value("readback operand_a", fu_data.operand_a, w0);
        check_value("readback operand_b", fu_data.operand_b, w1);
        end_test("readback");

        // forwarding and the stalls on a missing or CSR result
        clobber[5] = ALU;
        clobber[6] = MULT;
        rs1_valid  = 1'b1;
        rs2_valid  = 1'b1;
        rs1_data   = $urandom;
        rs2_data   = $urandom;
        ins        = make_instr(ALU, 5, 6, 8);
        issue_and_wait(ins);
        check_value("forwarded operand_a", fu_data.operand_a, rs1_data);
        check_value("forwarded operand_b", fu_data.operand_b, rs2_data);
        rs2_valid = 1'b0;
        refuse(ins, 2);
        rs2_valid = 1'b1;
        rs1_valid = 1'b0;
        refuse(ins, 2);
        rs1_valid  = 1'b1;
        clobber[5] = CSR;
        refuse(ins, 2);
        clear_clobber();
        rs1_valid = 1'b0;
        rs2_valid = 1'b0;
        end_test("forward");

        // WAW on rd released by a commit in the same cycle
        clobber[9] = LOAD;
        ins        = make_instr(ALU, 5, 6, 9);
        refuse(ins, 2);
        commit[0] = '{waddr: 9, wdata: $urandom, we: 1'b1};
        accept_now(ins);
        commit = '0;
        clear_clobber();
        end_test("waw");

        // unit routing with a busy lsu and an exception
        foreach (units[i]) begin
            issue_and_wait(make_instr(units[i], 1, 2, 3));
        end
        ready.lsu = 1'b0;
        refuse(make_instr(LOAD, 1, 2, 4), 2);
        ready.lsu = 1'b1;
        ready.flu = 1'b0;
        ins          = make_instr(ALU, 1, 2, 3);
        ins.ex_valid = 1'b1;
        accept_now(ins);
        check_value("valid after exception", xlen_t'(valid), '0);
        ready.flu = 1'b1;
        end_test("routing");

        // pc and immediate overrides and the zero register
        ins        = make_instr(ALU, 5, 6, 3);
        ins.use_pc = 1'b1;
        issue_and_wait(ins);
        check_value("pc operand_a", fu_data.operand_a, ins.pc);
        ins.use_pc  = 1'b0;
        ins.use_imm = 1'b1;
        issue_and_wait(ins);
        check_value("imm operand_b", fu_data.operand_b, ins.result);
        ins.fu = STORE;
        issue_and_wait(ins);
        check_value("store operand_b", fu_data.operand_b, shadow[6]);
        ins.fu = CTRL_FLOW;
        issue_and_wait(ins);
        check_value("branch operand_b", fu_data.operand_b, shadow[6]);
        write_regs(0, $urandom, 0, $urandom);
        issue_and_wait(make_instr(ALU, 0, 0, 3));
        check_value("x0 operand_a", fu_data.operand_a, '0);
        check_value("x0 operand_b", fu_data.operand_b, '0);
        end_test("override");

        // a multiply blocks other units for one cycle and flush clears the pulses
        ins = make_instr(MULT, 5, 6, 10);
        issue_and_wait(ins);
        refuse(make_instr(ALU, 5, 6, 11), 1);
        accept_now(make_instr(ALU, 5, 6, 11));
        issue_and_wait(ins);
        accept_now(ins);
        flush = 1'b1;
        accept_now(ins);
        flush = 1'b0;
        check_value("valid after flush", xlen_t'(valid), '0);
        end_test("mult_flush");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: logic/issue_read_operands.sv
// ----------------------------------------
// issue and operand read stage, top level
// hazard checker, GPR file, ID/EX register
// ----------------------------------------

`timescale 1ns/1ps

`include "issue_defs.svh"

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          flush_i,
    // instruction from the scoreboard
    input  issue_pkg::scoreboard_entry_t                  issue_instr_i,
    input  logic                                          issue_instr_valid_i,
    output logic                                          issue_ack_o,
    // scoreboard result lookup
    output isa_pkg::reg_addr_t                            rs1_o,
    input  isa_pkg::xlen_t                                rs1_i,
    input  logic                                          rs1_valid_i,
    output isa_pkg::reg_addr_t                            rs2_o,
    input  isa_pkg::xlen_t                                rs2_i,
    input  logic                                          rs2_valid_i,
    input  issue_pkg::clobber_table_t                     clobber_i,
    // commit write-back
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    input  issue_pkg::fu_ready_t                          ready_i,
    // to the execute stage
    output issue_pkg::fu_data_t                           fu_data_o,
    output issue_pkg::fu_valid_t                          valid_o,
    output isa_pkg::xlen_t                                pc_o,
    output logic                                          is_compressed_o
);
    import isa_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    logic  mult_pending;
    xlen_t rdata_a;
    xlen_t rdata_b;

    // scoreboard lookup by source index
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    issue_hazard_check #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) issue_hazard_check_inst (
        .issue_instr_i       ( issue_instr_i       ),
        .issue_instr_valid_i ( issue_instr_valid_i ),
        .clobber_i           ( clobber_i           ),
        .commit_i            ( commit_i            ),
        .rs1_valid_i         ( rs1_valid_i         ),
        .rs2_valid_i         ( rs2_valid_i         ),
        .ready_i             ( ready_i             ),
        .mult_pending_i      ( mult_pending        ),
        .fwd_rs1_o           ( fwd_rs1             ),
        .fwd_rs2_o           ( fwd_rs2             ),
        .issue_ack_o         ( issue_ack_o         )
    );

    gpr_regfile #(
        .NR_WRITE_PORTS ( NR_COMMIT_PORTS )
    ) gpr_regfile_inst (
        .clk_i     ( clk_i             ),
        .rst_ni    ( rst_ni            ),
        .raddr_a_i ( issue_instr_i.rs1 ),
        .raddr_b_i ( issue_instr_i.rs2 ),
        .rdata_a_o ( rdata_a           ),
        .rdata_b_o ( rdata_b           ),
        .commit_i  ( commit_i          )
    );

    issue_register issue_register_inst (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .flush_i             ( flush_i             ),
        .issue_instr_i       ( issue_instr_i       ),
        .issue_instr_valid_i ( issue_instr_valid_i ),
        .issue_ack_i         ( issue_ack_o         ),
        .fwd_rs1_i           ( fwd_rs1             ),
        .fwd_rs2_i           ( fwd_rs2             ),
        .rs1_i               ( rs1_i               ),
        .rs2_i               ( rs2_i               ),
        .rdata_a_i           ( rdata_a             ),
        .rdata_b_i           ( rdata_b             ),
        .mult_pending_o      ( mult_pending        ),
        .fu_data_o           ( fu_data_o           ),
        .valid_o             ( valid_o             ),
        .pc_o                ( pc_o                ),
        .is_compressed_o     ( is_compressed_o     )
    );

endmodule

// File: logic/issue_register.sv
// ----------------------------------------
// operand select and ID/EX register
// per-unit valid pulses with flush
// ----------------------------------------

`timescale 1ns/1ps

module issue_register (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    input  issue_pkg::scoreboard_entry_t issue_instr_i,
    input  logic                         issue_instr_valid_i,
    input  logic                         issue_ack_i,
    input  logic                         fwd_rs1_i,
    input  logic                         fwd_rs2_i,
    input  isa_pkg::xlen_t               rs1_i,
    input  isa_pkg::xlen_t               rs2_i,
    input  isa_pkg::xlen_t               rdata_a_i,
    input  isa_pkg::xlen_t               rdata_b_i,
    output logic                         mult_pending_o,
    output issue_pkg::fu_data_t          fu_data_o,
    output issue_pkg::fu_valid_t         valid_o,
    output isa_pkg::xlen_t               pc_o,
    output logic                         is_compressed_o
);
    import isa_pkg::*;
    import issue_pkg::*;

    fu_data_t  fu_data_d;
    fu_data_t  fu_data_q;
    fu_valid_t valid_d;
    fu_valid_t valid_q;
    logic      accept;

    // ----------------------------------------
    // operand mux
    // ----------------------------------------
    always_comb begin : operand_sel
        fu_data_d.fu        = issue_instr_i.fu;
        fu_data_d.op        = issue_instr_i.op;
        fu_data_d.trans_id  = issue_instr_i.trans_id;
        fu_data_d.imm       = issue_instr_i.result;
        // register file by default, scoreboard result when forwarded
        fu_data_d.operand_a = fwd_rs1_i ? rs1_i : rdata_a_i;
        fu_data_d.operand_b = fwd_rs2_i ? rs2_i : rdata_b_i;
        if (issue_instr_i.use_pc) begin
            fu_data_d.operand_a = issue_instr_i.pc;
        end
        // stores and branches need rs2 in operand b, imm goes via the imm field
        if (issue_instr_i.use_imm && issue_instr_i.fu != STORE &&
            issue_instr_i.fu != CTRL_FLOW) begin
            fu_data_d.operand_b = issue_instr_i.result;
        end
    end

    // ----------------------------------------
    // unit valid pulses
    // ----------------------------------------
    assign accept = issue_instr_valid_i && issue_ack_i && !issue_instr_i.ex_valid;

    always_comb begin : valid_sel
        valid_d = '0;
        if (accept && !flush_i) begin
            case (issue_instr_i.fu)
                ALU:         valid_d.alu    = 1'b1;
                CTRL_FLOW:   valid_d.branch = 1'b1;
                LOAD, STORE: valid_d.lsu    = 1'b1;
                MULT:        valid_d.mult   = 1'b1;
                CSR:         valid_d.csr    = 1'b1;
                default:     valid_d        = '0;
            endcase
        end
    end

    // data loads every cycle, valid only marks the issued one
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_q.fu        <= NONE;
            fu_data_q.op        <= ADD;
            fu_data_q.operand_a <= '0;
            fu_data_q.operand_b <= '0;
            fu_data_q.imm       <= '0;
            fu_data_q.trans_id  <= '0;
            valid_q             <= '0;
            pc_o                <= '0;
            is_compressed_o     <= 1'b0;
        end else begin
            fu_data_q       <= fu_data_d;
            valid_q         <= valid_d;
            pc_o            <= issue_instr_i.pc;
            is_compressed_o <= issue_instr_i.is_compressed;
        end
    end

    assign fu_data_o      = fu_data_q;
    assign valid_o        = valid_q;
    // multiply issued last cycle, blocks non-multiplies
    assign mult_pending_o = valid_q.mult;

endmodule

// File: logic/gpr_regfile.sv
// ----------------------------------------
// integer register file
// two async read ports, commit write ports
// x0 hard-wired to zero
// ----------------------------------------

`timescale 1ns/1ps

`include "issue_defs.svh"

module gpr_regfile #(
    parameter int unsigned NR_WRITE_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  isa_pkg::reg_addr_t                            raddr_a_i,
    input  isa_pkg::reg_addr_t                            raddr_b_i,
    output isa_pkg::xlen_t                                rdata_a_o,
    output isa_pkg::xlen_t                                rdata_b_o,
    input  issue_pkg::commit_port_t [NR_WRITE_PORTS-1:0]  commit_i
);
    import isa_pkg::*;

    // registers 1..31, x0 has no storage
    xlen_t [2**`ISSUE_REG_ADDR_SIZE-1:1] mem_q;

    // later ports overwrite earlier ones on an address clash
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q <= '0;
        end else begin
            for (int unsigned i = 0; i < NR_WRITE_PORTS; i++) begin
                if (commit_i[i].we && commit_i[i].waddr != '0) begin
                    mem_q[commit_i[i].waddr] <= commit_i[i].wdata;
                end
            end
        end
    end

    // reads see the value before this cycle's writes
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

// File: logic/issue_hazard_check.sv
// ----------------------------------------
// operand availability and forwarding,
// unit busy, WAW check, issue acknowledge
// ----------------------------------------

`timescale 1ns/1ps

`include "issue_defs.svh"

module issue_hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  issue_pkg::scoreboard_entry_t                      issue_instr_i,
    input  logic                                              issue_instr_valid_i,
    input  issue_pkg::clobber_table_t                         clobber_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]     commit_i,
    input  logic                                              rs1_valid_i,
    input  logic                                              rs2_valid_i,
    input  issue_pkg::fu_ready_t                              ready_i,
    input  logic                                              mult_pending_i,
    output logic                                              fwd_rs1_o,
    output logic                                              fwd_rs2_o,
    output logic                                              issue_ack_o
);
    import issue_pkg::*;

    logic stall;
    logic fu_busy;
    logic rd_free;

    // ----------------------------------------
    // source operands
    // ----------------------------------------
    // a clobbered source is taken from the scoreboard when its result is there
    // CSR results only ever come back through the register file
    always_comb begin : src_check
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        if (clobber_i[issue_instr_i.rs1] != NONE) begin
            if (rs1_valid_i && clobber_i[issue_instr_i.rs1] != CSR) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (clobber_i[issue_instr_i.rs2] != NONE) begin
            if (rs2_valid_i && clobber_i[issue_instr_i.rs2] != CSR) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy flag of the unit this instruction goes to
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~ready_i.flu;
            LOAD, STORE:               fu_busy = ~ready_i.lsu;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------
    // WAW check
    // ----------------------------------------
    // rd is free when no writer is pending or a commit retires it right now
    always_comb begin : waw_check
        rd_free = (clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && commit_i[i].waddr == issue_instr_i.rd) begin
                rd_free = 1'b1;
            end
        end
    end

    // acknowledge in the same cycle
    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions just retire through
            if (issue_instr_i.ex_valid || issue_instr_i.fu == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the flu result bus is taken for a cycle after a multiply
        if (mult_pending_i && issue_instr_i.fu != MULT) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

// File: logic/issue_pkg.sv
// ----------------------------------------
// pipeline types of the issue stage
// unit enum, scoreboard entry, clobber
// table, commit port, ready/valid, ID/EX
// ----------------------------------------

`include "issue_defs.svh"

package issue_pkg;

    // scoreboard transaction id
    typedef logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id_t;

    // functional unit selector, NONE means no unit needed
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    // one decoded instruction as handed over by the scoreboard
    typedef struct packed {
        isa_pkg::xlen_t     pc;
        trans_id_t          trans_id;
        fu_t                fu;
        isa_pkg::fu_op_t    op;
        isa_pkg::reg_addr_t rs1;
        isa_pkg::reg_addr_t rs2;
        isa_pkg::reg_addr_t rd;
        // holds the immediate at issue time
        isa_pkg::xlen_t     result;
        logic               use_imm;
        logic               use_pc;
        logic               ex_valid;
        logic               is_compressed;
    } scoreboard_entry_t;

    // pending writer per register, NONE when nothing is in flight
    typedef fu_t [2**`ISSUE_REG_ADDR_SIZE-1:0] clobber_table_t;

    // one commit write port into the register file
    typedef struct packed {
        isa_pkg::reg_addr_t waddr;
        isa_pkg::xlen_t     wdata;
        logic               we;
    } commit_port_t;

    // unit ready levels
    typedef struct packed {
        // fixed latency unit: alu, branch, mult, csr
        logic flu;
        logic lsu;
    } fu_ready_t;

    // one-cycle issue pulses per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

    // ID/EX payload
    typedef struct packed {
        fu_t             fu;
        isa_pkg::fu_op_t op;
        isa_pkg::xlen_t  operand_a;
        isa_pkg::xlen_t  operand_b;
        isa_pkg::xlen_t  imm;
        trans_id_t       trans_id;
    } fu_data_t;

endpackage

// File: logic/isa_pkg.sv
// ----------------------------------------
// architectural types
// data word, register index, operator
// ----------------------------------------

`include "issue_defs.svh"

package isa_pkg;

    // one integer data word
    typedef logic [`ISSUE_XLEN-1:0] xlen_t;

    // one integer register index
    typedef logic [`ISSUE_REG_ADDR_SIZE-1:0] reg_addr_t;

    // operator carried along to the execute units
    // the issue stage never decodes it
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        BEQ,
        BNE,
        JAL,
        LW,
        SW,
        MUL,
        CSRRW
    } fu_op_t;

endpackage

// File: logic/issue_defs.svh
// ----------------------------------------
// widths and default sizes shared by the
// issue stage packages and modules
// ----------------------------------------

`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// integer data word width
`define ISSUE_XLEN 32

// architectural register index width, 32 registers
`define ISSUE_REG_ADDR_SIZE 5

// scoreboard transaction id width
`define ISSUE_TRANS_ID_BITS 3

// commit ports writing back into the register file
`define ISSUE_NR_COMMIT_PORTS 2

`endif
